/* bench/frame_fifo_tb.sv */
`timescale 1ns/1ps

module frame_fifo_tb import frame_fifo_pkg::*; ();

    localparam int addr_width = 4;
    localparam int depth = 2 ** addr_width;
    // frames 1..12, third group, fourth group, forty random frames of at most 8 beats
    localparam int total_beats = 78 + 31 + 45 + 40 * 8;
    localparam int cycle_limit = 2 * total_beats + 2000;

    logic                  clk = 1'b0;
    logic                  rst;
    logic [63:0]           in_tdata;
    logic [7:0]            in_tkeep;
    logic                  in_tvalid;
    logic                  in_tready;
    logic                  in_tlast;
    logic                  in_tuser;
    logic [63:0]           out_tdata;
    logic [7:0]            out_tkeep;
    logic                  out_tvalid;
    logic                  out_tready;
    logic                  out_tlast;
    logic [STAT_WIDTH-1:0] good_count;
    logic [STAT_WIDTH-1:0] bad_count;
    logic [STAT_WIDTH-1:0] drop_count;

    int seed = 43;
    int error_count = 0;
    int check_count = 0;
    int cycle_count = 0;
    int exp_good = 0;
    int exp_bad = 0;
    int exp_drop = 0;
    // 0 holds out_tready low, 1 holds it high, 2 stalls at random
    int sink_mode = 0;
    logic [31:0] sink_rand;
    logic [31:0] frame_rand;
    int frame_len;
    // kept beats in order, {last, keep, data}
    logic [72:0] expected_q [$];
    logic [72:0] exp_beat;

    int p3_len [7] = '{4, 3, 7, 2, 5, 9, 1};
    bit p3_err [7] = '{0, 1, 0, 1, 0, 1, 0};
    // 20 beats never fits, the rest fill memory until rejected
    int p4_len [7] = '{5, 20, 6, 4, 7, 2, 1};

    always #50 clk = ~clk;

    frame_fifo_top #(
        .addr_width     (addr_width),
        .data_width     (64),
        .keep_width     (8),
        .drop_when_full (1'b1)
    ) frame_fifo_top_inst (
        .clk        (clk),
        .rst        (rst),
        .in_tdata   (in_tdata),
        .in_tkeep   (in_tkeep),
        .in_tvalid  (in_tvalid),
        .in_tready  (in_tready),
        .in_tlast   (in_tlast),
        .in_tuser   (in_tuser),
        .out_tdata  (out_tdata),
        .out_tkeep  (out_tkeep),
        .out_tvalid (out_tvalid),
        .out_tready (out_tready),
        .out_tlast  (out_tlast),
        .good_count (good_count),
        .bad_count  (bad_count),
        .drop_count (drop_count)
    );

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    // fate from the space rule, drop wins over the error flag
    function automatic frame_status_t predict_fate(input int len, input bit err,
                                                    input int unread);
        if (unread + len > depth) begin
            return status_drop;
        end else if (err) begin
            return status_bad;
        end
        return status_good;
    endfunction

    // oldest pending beat sits in the output register once loaded
    function automatic int unread_words();
        if (expected_q.size() > 0) begin
            return expected_q.size() - 1;
        end
        return 0;
    endfunction

    task automatic send_frame(input int len, input bit err, input bit gaps);
        logic [72:0] beats [$];
        logic [31:0] r_hi;
        logic [31:0] r_lo;
        logic [31:0] r_keep;
        logic ready;
        frame_status_t fate;
        fate = predict_fate(len, err, unread_words());
        for (int i = 0; i < len; i++) begin
            r_hi = $random(seed);
            r_lo = $random(seed);
            r_keep = $random(seed);
            beats.push_back({i == len - 1, r_keep[7:0], r_hi, r_lo});
        end
        case (fate)
            status_good: begin
                exp_good++;
                foreach (beats[j]) begin
                    expected_q.push_back(beats[j]);
                end
            end
            status_bad: exp_bad++;
            default: exp_drop++;
        endcase
        foreach (beats[j]) begin
            // optional idle cycles before each beat
            if (gaps) begin
                r_hi = $random(seed);
                while (r_hi[1:0] == 2'b00) begin
                    in_tvalid = 1'b0;
                    @(posedge clk);
                    #1;
                    r_hi = $random(seed);
                end
            end
            {in_tlast, in_tkeep, in_tdata} = beats[j];
            in_tuser = err && beats[j][72];
            in_tvalid = 1'b1;
            // ready sampled mid cycle, transfer on the next edge
            do begin
                @(negedge clk);
                ready = in_tready;
                @(posedge clk);
                #1;
            end while (!ready);
        end
        in_tvalid = 1'b0;
        in_tlast = 1'b0;
        in_tuser = 1'b0;
    endtask

    // pending plus new frame must fit, so the frame is always kept or rewound
    task automatic wait_room(input int len);
        while (expected_q.size() + len > depth) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic drain_output();
        while (expected_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
        repeat (4) @(posedge clk);
        #1;
    endtask

    task automatic check_counters();
        check_value("good_count", 64'(good_count), 64'(exp_good));
        check_value("bad_count", 64'(bad_count), 64'(exp_bad));
        check_value("drop_count", 64'(drop_count), 64'(exp_drop));
    endtask

    // sink side, the only driver of out_tready
    initial begin
        out_tready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (sink_mode == 1) begin
                out_tready = 1'b1;
            end else if (sink_mode == 2) begin
                sink_rand = $random(seed);
                out_tready = (sink_rand[1:0] != 2'b00);
            end else begin
                out_tready = 1'b0;
            end
        end
    end

    // output compare, mid cycle so both handshake levels are settled
    always @(negedge clk) begin
        if (!rst && out_tvalid && out_tready) begin
            if (expected_q.size() == 0) begin
                error_count++;
                $display("output beat arrived while no kept frame was pending");
            end else begin
                exp_beat = expected_q.pop_front();
                check_value("out_tdata", out_tdata, exp_beat[63:0]);
                check_value("out_tkeep", 64'(out_tkeep), 64'(exp_beat[71:64]));
                check_value("out_tlast", 64'(out_tlast), 64'(exp_beat[72]));
            end
        end
    end

    // watchdog
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: test did not finish within %0d cycles", cycle_limit);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        rst = 1'b1;
        in_tdata = '0;
        in_tkeep = '0;
        in_tvalid = 1'b0;
        in_tlast = 1'b0;
        in_tuser = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        // idle state after reset
        @(negedge clk);
        check_value("out_tvalid", 64'(out_tvalid), 64'd0);
        check_value("in_tready", 64'(in_tready), 64'd1);
        check_counters();
        @(posedge clk);
        #1;

        // good frames of growing length, sink always ready
        sink_mode = 1;
        for (int n = 1; n <= 12; n++) begin
            wait_room(n);
            send_frame(n, 1'b0, 1'b0);
        end
        drain_output();
        check_counters();

        // bad frames mixed with good ones
        for (int n = 0; n < 7; n++) begin
            wait_room(p3_len[n]);
            send_frame(p3_len[n], p3_err[n], 1'b0);
        end
        drain_output();
        check_counters();

        // sink stalled, memory fills until frames are rejected
        sink_mode = 0;
        repeat (2) @(posedge clk);
        #1;
        for (int n = 0; n < 7; n++) begin
            send_frame(p4_len[n], 1'b0, 1'b0);
            repeat (5) @(posedge clk);
            #1;
        end
        sink_mode = 1;
        drain_output();
        check_counters();

        // random stalls on both sides
        sink_mode = 2;
        for (int n = 0; n < 40; n++) begin
            frame_rand = $random(seed);
            frame_len = int'(frame_rand[2:0]) + 1;
            wait_room(frame_len);
            send_frame(frame_len, frame_rand[6:4] == 3'b000, 1'b1);
        end
        sink_mode = 1;
        drain_output();
        check_counters();

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* design/frame_fifo_ctrl.sv */
`timescale 1ns/1ps

module frame_fifo_ctrl import frame_fifo_pkg::*; #(
    parameter int addr_width     = 12,
    parameter bit drop_when_full = 1'b0
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_tvalid,
    output logic                  in_tready,
    input  logic                  in_tlast,
    input  logic                  in_tuser,
    output logic                  wr_en,
    output logic [addr_width-1:0] wr_addr,
    output logic                  rd_en,
    output logic [addr_width-1:0] rd_addr,
    output logic                  out_tvalid,
    input  logic                  out_tready,
    output logic                  frame_done,
    output frame_status_t         frame_status
);

    localparam int depth = 2 ** addr_width;

    // pointers carry one extra bit to tell full from empty
    // committed write pointer, end of the last good frame
    logic [addr_width:0] wr_ptr;
    // write position inside the frame being received
    logic [addr_width:0] wr_ptr_cur;
    // next word to move into the output register
    logic [addr_width:0] rd_ptr;
    // set once the current frame has lost a beat
    logic                drop_frame;

    // written but not yet read, current frame included
    logic [addr_width:0] used_words;
    // committed words waiting for the output register
    logic [addr_width:0] ready_words;
    logic                full;
    logic                empty;
    logic                stall;
    logic                accept;
    logic                overflow;

    assign used_words  = wr_ptr_cur - rd_ptr;
    assign ready_words = wr_ptr - rd_ptr;

    // full when top bits differ and address bits match
    assign full = (wr_ptr_cur[addr_width] != rd_ptr[addr_width]) &&
                  (wr_ptr_cur[addr_width-1:0] == rd_ptr[addr_width-1:0]);
    // nothing committed left to read
    assign empty = (wr_ptr == rd_ptr);

    // stall only while committed words can still drain
    // a frame that fills the whole memory by itself can never fit, so it is dropped
    assign stall     = !drop_when_full && full && !empty;
    assign in_tready = !stall;
    assign accept    = in_tvalid && in_tready;

    // no room for this beat, or an earlier beat was already lost
    assign overflow = full || drop_frame;

    assign wr_en   = accept && !overflow;
    assign wr_addr = wr_ptr_cur[addr_width-1:0];

    // fetch when the output register is free or being taken
    assign rd_en   = (out_tready || !out_tvalid) && !empty;
    assign rd_addr = rd_ptr[addr_width-1:0];

    // write side with commit, rewind and drop
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr       <= '0;
            wr_ptr_cur   <= '0;
            drop_frame   <= 1'b0;
            frame_done   <= 1'b0;
            frame_status <= status_good;
        end else begin
            // status pulse lasts a single cycle
            frame_done <= 1'b0;
            if (accept) begin
                if (overflow) begin
                    // swallow the rest of the frame
                    drop_frame <= 1'b1;
                    if (in_tlast) begin
                        // reclaim whatever part was written
                        wr_ptr_cur   <= wr_ptr;
                        drop_frame   <= 1'b0;
                        frame_done   <= 1'b1;
                        frame_status <= status_drop;
                    end
                end else begin
                    wr_ptr_cur <= wr_ptr_cur + 1'b1;
                    if (in_tlast) begin
                        frame_done <= 1'b1;
                        if (in_tuser) begin
                            // error on last beat, rewind
                            wr_ptr_cur   <= wr_ptr;
                            frame_status <= status_bad;
                        end else begin
                            // publish the frame to the read side
                            wr_ptr       <= wr_ptr_cur + 1'b1;
                            frame_status <= status_good;
                        end
                    end
                end
            end
        end
    end

    // read pointer follows the output register loads
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_ptr <= '0;
        end else if (rd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // output valid level, held until taken
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_tvalid <= 1'b0;
        end else if (out_tready || !out_tvalid) begin
            out_tvalid <= !empty;
        end
    end

    // unread data is never overwritten
    a_occupancy: assert property (@(posedge clk) disable iff (rst)
        used_words <= depth);

    // committed pointer sits between read and current write pointers
    a_read_ok: assert property (@(posedge clk) disable iff (rst)
        ready_words <= used_words);

endmodule

/* design/frame_fifo_pkg.sv */
package frame_fifo_pkg;

    // fate of a finished frame, reported once per last beat
    // good frames are committed and will reach the output
    // bad frames carried the error flag and were rewound
    // dropped frames did not fit in the free words
    typedef enum logic [1:0] {
        status_good = 2'd0,
        status_bad  = 2'd1,
        status_drop = 2'd2
    } frame_status_t;

    // width of each frame counter
    // shared by the statistics block and the top level ports
    localparam int STAT_WIDTH = 16;

endpackage

/* design/frame_fifo_top.sv */
`timescale 1ns/1ps

module frame_fifo_top import frame_fifo_pkg::*; #(
    parameter int addr_width     = 12,
    parameter int data_width     = 64,
    parameter int keep_width     = data_width / 8,
    parameter bit drop_when_full = 1'b0
) (
    input  logic                  clk,
    input  logic                  rst,

    // input stream
    input  logic [data_width-1:0] in_tdata,
    input  logic [keep_width-1:0] in_tkeep,
    input  logic                  in_tvalid,
    output logic                  in_tready,
    input  logic                  in_tlast,
    input  logic                  in_tuser,

    // output stream
    output logic [data_width-1:0] out_tdata,
    output logic [keep_width-1:0] out_tkeep,
    output logic                  out_tvalid,
    input  logic                  out_tready,
    output logic                  out_tlast,

    // frame counters
    output logic [STAT_WIDTH-1:0] good_count,
    output logic [STAT_WIDTH-1:0] bad_count,
    output logic [STAT_WIDTH-1:0] drop_count
);

    localparam int word_width = data_width + keep_width + 1;

    logic                  wr_en;
    logic [addr_width-1:0] wr_addr;
    logic                  rd_en;
    logic [addr_width-1:0] rd_addr;
    logic [word_width-1:0] wr_word;
    logic [word_width-1:0] rd_word;
    logic                  frame_done;
    frame_status_t         frame_status;

    // last sits on top so it travels with its beat
    assign wr_word = {in_tlast, in_tkeep, in_tdata};
    assign {out_tlast, out_tkeep, out_tdata} = rd_word;

    frame_fifo_ctrl #(
        .addr_width     (addr_width),
        .drop_when_full (drop_when_full)
    ) frame_fifo_ctrl_inst (
        .clk          (clk),
        .rst          (rst),
        .in_tvalid    (in_tvalid),
        .in_tready    (in_tready),
        .in_tlast     (in_tlast),
        .in_tuser     (in_tuser),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .rd_en        (rd_en),
        .rd_addr      (rd_addr),
        .out_tvalid   (out_tvalid),
        .out_tready   (out_tready),
        .frame_done   (frame_done),
        .frame_status (frame_status)
    );

    frame_ram #(
        .addr_width (addr_width),
        .data_width (data_width),
        .keep_width (keep_width)
    ) frame_ram_inst (
        .clk        (clk),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_word    (wr_word),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .out_tready (out_tready),
        .out_tvalid (out_tvalid),
        .rd_word    (rd_word)
    );

    frame_stats frame_stats_inst (
        .clk          (clk),
        .rst          (rst),
        .frame_done   (frame_done),
        .frame_status (frame_status),
        .good_count   (good_count),
        .bad_count    (bad_count),
        .drop_count   (drop_count)
    );

endmodule

/* design/frame_ram.sv */
`timescale 1ns/1ps

module frame_ram #(
    parameter  int addr_width = 12,
    parameter  int data_width = 64,
    parameter  int keep_width = data_width / 8,
    localparam int word_width = data_width + keep_width + 1
) (
    input  logic                  clk,
    input  logic                  wr_en,
    input  logic [addr_width-1:0] wr_addr,
    input  logic [word_width-1:0] wr_word,
    input  logic                  rd_en,
    input  logic [addr_width-1:0] rd_addr,
    input  logic                  out_tready,
    input  logic                  out_tvalid,
    output logic [word_width-1:0] rd_word
);

    localparam int depth = 2 ** addr_width;

    // one word per beat, {last, keep, data}
    logic [word_width-1:0] mem [depth];

    // write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_word;
        end
    end

    // registered read, this is the output stage
    // loads only when the control side fetches
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_word <= mem[rd_addr];
        end
    end

    // output word holds while the sink stalls
    a_hold: assert property (@(posedge clk)
        out_tvalid && !out_tready |=> $stable(rd_word));

endmodule

/* design/frame_stats.sv */
`timescale 1ns/1ps

module frame_stats import frame_fifo_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  frame_done,
    input  frame_status_t         frame_status,
    output logic [STAT_WIDTH-1:0] good_count,
    output logic [STAT_WIDTH-1:0] bad_count,
    output logic [STAT_WIDTH-1:0] drop_count
);

    // add one unless already at all ones
    function automatic logic [STAT_WIDTH-1:0] sat_inc(
        input logic [STAT_WIDTH-1:0] value
    );
        if (&value) begin
            return value;
        end else begin
            return value + 1'b1;
        end
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            good_count <= '0;
            bad_count  <= '0;
            drop_count <= '0;
        end else if (frame_done) begin
            // one counter per pulse, picked by status
            case (frame_status)
                status_good: begin
                    good_count <= sat_inc(good_count);
                end
                status_bad: begin
                    bad_count <= sat_inc(bad_count);
                end
                status_drop: begin
                    drop_count <= sat_inc(drop_count);
                end
                default: begin
                    good_count <= good_count;
                end
            endcase
        end
    end

    // the control side only reports known fates
    a_status_known: assert property (@(posedge clk) disable iff (rst)
        frame_done |-> frame_status inside {status_good, status_bad, status_drop});

endmodule

/* run.sh */
#!/bin/sh
# build with Verilator, run, and scan the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module frame_fifo_tb \
    -f sim.f -o frame_fifo_sim \
    && ./obj_dir/frame_fifo_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "FAIL: see errors above" sim.log && exit 1
exit 0

/* sim.f */
design/frame_fifo_pkg.sv
design/frame_fifo_ctrl.sv
design/frame_ram.sv
design/frame_stats.sv
design/frame_fifo_top.sv
bench/frame_fifo_tb.sv
